//--- hdl/clk_ctrl_pkg.sv
// clock control shared definitions
// config bus, pll controls, register map
package clk_ctrl_pkg;

  typedef struct packed {
    logic        we;     // 1 = write
    logic [1:0]  addr;   // word index
    logic [31:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic        ack;    // four-phase ack
    logic [31:0] rdata;  // valid with ack on reads
  } cfg_rsp_t;

  typedef struct packed {
    logic        rstn;          // pll reset release
    logic        ps0_en;        // output 0 enable
    logic        bypass;        // refclk straight through
    logic [7:0]  ps0_l2;        // post divider
    logic [10:0] mul_int;       // feedback multiplier
    logic        integer_mode;
    logic [3:0]  prescale;      // ref prescaler
    logic [2:0]  lf_hi;         // loop filter top bits
  } pll_ctrl_t;

  localparam logic [1:0] CFG0_ADDR = 2'd0;
  localparam logic [1:0] CFG1_ADDR = 2'd1;
  localparam logic [1:0] CFG2_ADDR = 2'd2;
  localparam logic [1:0] CFG3_ADDR = 2'd3;

  localparam logic [31:0] CFG0_RST = 32'h0000_0000; // reset bit low, pll held
  localparam logic [31:0] CFG1_RST = 32'h0000_0004; // bypass on
  localparam logic [31:0] CFG2_RST = 32'h0000_0064;
  localparam logic [31:0] CFG3_RST = 32'h0000_0269;

  localparam int CFG0_RSTN_BIT = 2;
  localparam int L2_LSB        = 4;   // cfg0
  localparam int L2_MSB        = 11;
  localparam int EN_BIT        = 0;   // cfg1
  localparam int BYPASS_BIT    = 2;
  localparam int MUL_LSB       = 4;
  localparam int MUL_MSB       = 14;
  localparam int INT_MODE_BIT  = 27;
  localparam int PRESCALE_LSB  = 28;
  localparam int LOCK_RD_BIT   = 31;  // cfg2 readback
  localparam int LFHI_RD_BIT   = 30;
  localparam int LF_SRC_LSB    = 29;  // cfg2 source of lf_hi
  localparam int LF_SRC_MSB    = 31;

  localparam int LOCK_CYCLES = 32;    // release to lock, clk cycles
  localparam logic [31:0] BOOT_CFG1 = (32'd20 << MUL_LSB) | (32'd1 << EN_BIT);
  localparam logic [31:0] BOOT_CFG0 = (32'd1 << L2_LSB) | (32'd1 << CFG0_RSTN_BIT);
  localparam int BOOT_POLL_MAX = 64;  // lock polls before giving up

endpackage

//--- hdl/pll_cfg_regs.sv
// pll configuration registers
module pll_cfg_regs import clk_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      RSTB,
  input  logic      req,
  input  cfg_req_t  cmd,
  input  logic      lock,
  output cfg_rsp_t  rsp,
  output pll_ctrl_t ctrl
);

  logic [31:0] cfg0;
  logic [31:0] cfg1;
  logic [31:0] cfg2;
  logic [31:0] cfg3;
  logic [2:0]  lf_hi;    // latched loop filter bits
  logic        ack_q;
  logic [31:0] rdata_q;
  logic [31:0] rd_mux;
  logic        access;

  assign access = req & ~ack_q; // first req cycle only

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      cfg0  <= CFG0_RST;
      cfg1  <= CFG1_RST;
      cfg2  <= CFG2_RST;
      cfg3  <= CFG3_RST;
      lf_hi <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= req; // up after access, down after req drops
      if (access && cmd.we) begin
        case (cmd.addr)
          CFG0_ADDR: cfg0 <= cmd.wdata;
          CFG1_ADDR: cfg1 <= cmd.wdata;
          CFG2_ADDR: cfg2 <= cmd.wdata;
          CFG3_ADDR: begin
            cfg3  <= cmd.wdata;
            lf_hi <= cfg2[LF_SRC_MSB:LF_SRC_LSB]; // old cfg2 top bits
          end
        endcase
      end
    end
  end

  // readback, cfg2 carries status on top
  always_comb begin
    case (cmd.addr)
      CFG0_ADDR: rd_mux = cfg0;
      CFG1_ADDR: rd_mux = cfg1;
      CFG2_ADDR: begin
        rd_mux              = cfg2;
        rd_mux[LOCK_RD_BIT] = lock;     // live lock status
        rd_mux[LFHI_RD_BIT] = lf_hi[0];
      end
      default: rd_mux = cfg3;
    endcase
  end

  always_ff @(posedge clk) begin
    if (access && !cmd.we) begin
      rdata_q <= rd_mux; // held until next read
    end
  end

  assign rsp = '{ack: ack_q, rdata: rdata_q};

  // field decode to pll
  always_comb begin
    ctrl.rstn         = cfg0[CFG0_RSTN_BIT];
    ctrl.ps0_l2       = cfg0[L2_MSB:L2_LSB];
    ctrl.ps0_en       = cfg1[EN_BIT];
    ctrl.bypass       = cfg1[BYPASS_BIT];
    ctrl.mul_int      = cfg1[MUL_MSB:MUL_LSB];
    ctrl.integer_mode = cfg1[INT_MODE_BIT];
    ctrl.prescale     = cfg1[PRESCALE_LSB +: 4];
    ctrl.lf_hi        = lf_hi;
  end

endmodule

//--- hdl/pll_model.sv
// behavioral pll model
module pll_model import clk_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      RSTB,
  input  logic      refclk,
  input  pll_ctrl_t ctrl,
  output logic      lock,
  output logic      pll_clk
);

  logic                           run;      // released and enabled
  logic [$clog2(LOCK_CYCLES)-1:0] lock_cnt;
  logic [7:0]                     div_cnt;
  logic                           clk_div;  // divided output

  assign run = ctrl.rstn & ctrl.ps0_en;

  // lock after LOCK_CYCLES of run
  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      lock_cnt <= '0;
      lock     <= 1'b0;
    end else if (!run) begin
      lock_cnt <= '0; // restart on any drop
      lock     <= 1'b0;
    end else if (!lock) begin
      lock_cnt <= lock_cnt + 1'b1;
      if (lock_cnt == LOCK_CYCLES - 1) begin
        lock <= 1'b1;
      end
    end
  end

  // output divider, toggles every ps0_l2+1 cycles
  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      div_cnt <= '0;
      clk_div <= 1'b0;
    end else if (!ctrl.rstn || !lock) begin
      div_cnt <= '0;
      clk_div <= 1'b0; // parked low until locked
    end else if (div_cnt == ctrl.ps0_l2) begin
      div_cnt <= '0;
      clk_div <= ~clk_div;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign pll_clk = ctrl.bypass ? refclk : clk_div; // bypass passes refclk

endmodule

//--- hdl/cfg_arbiter.sv
// round-robin config bus arbiter
module cfg_arbiter import clk_ctrl_pkg::*; (
  input  logic     clk,
  input  logic     RSTB,
  input  logic     req_a,
  input  logic     req_b,
  input  cfg_req_t cmd_a,
  input  cfg_req_t cmd_b,
  input  cfg_rsp_t rsp,
  output cfg_rsp_t rsp_a,
  output cfg_rsp_t rsp_b,
  output logic     req,
  output cfg_req_t cmd
);

  logic busy;   // transaction in flight
  logic owner;  // 0 = a, 1 = b, also last winner
  logic pick;   // winner if idle now
  logic sel;

  // on contention the last loser wins
  assign pick = (req_a & req_b) ? ~owner : req_b;
  assign sel  = busy ? owner : pick;

  // grant is immediate when idle
  assign req = busy ? (owner ? req_b : req_a) : (req_a | req_b);
  assign cmd = sel ? cmd_b : cmd_a;

  // ack only to the owner
  assign rsp_a = '{ack: rsp.ack & busy & ~owner, rdata: rsp.rdata};
  assign rsp_b = '{ack: rsp.ack & busy & owner, rdata: rsp.rdata};

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      busy  <= 1'b0;
      owner <= 1'b0; // b first on contention
    end else if (!busy) begin
      if (req_a | req_b) begin
        busy  <= 1'b1;
        owner <= pick;
      end
    end else if (!req && !rsp.ack) begin
      busy <= 1'b0; // four phases done
    end
  end

endmodule

//--- hdl/apb_cfg_bridge.sv
// apb to config bus bridge
module apb_cfg_bridge import clk_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        RSTB,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  input  cfg_rsp_t    rsp,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        req,
  output cfg_req_t    cmd
);

  typedef enum logic [1:0] {BR_IDLE, BR_REQ, BR_ACKLO} state_t;

  state_t      state;
  logic [31:0] rdata_q;

  assign req     = (state == BR_REQ);
  assign pready  = req & rsp.ack;  // single cycle, access phase
  assign pslverr = 1'b0;
  assign prdata  = rsp.ack ? rsp.rdata : rdata_q;

  // apb holds addr and data until pready
  assign cmd = '{we: pwrite, addr: paddr[3:2], wdata: pwdata};

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      state <= BR_IDLE;
    end else begin
      case (state)
        BR_IDLE: if (psel && !penable) state <= BR_REQ; // setup phase
        BR_REQ: if (rsp.ack) state <= BR_ACKLO;
        // next setup may land while ack drains
        BR_ACKLO: if (!rsp.ack) state <= psel ? BR_REQ : BR_IDLE;
        default: state <= BR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pready) begin
      rdata_q <= rsp.rdata;
    end
  end

endmodule

//--- hdl/pll_boot_seq.sv
// post-reset pll boot sequencer
module pll_boot_seq import clk_ctrl_pkg::*; (
  input  logic     clk,
  input  logic     RSTB,
  input  cfg_rsp_t rsp,
  output logic     req,
  output cfg_req_t cmd,
  output logic     boot_done,
  output logic     boot_fail
);

  typedef enum logic [1:0] {ST_START, ST_REQ, ST_ACKLO, ST_HALT} state_t;
  typedef enum logic [1:0] {STEP_CFG1, STEP_CFG0, STEP_POLL} step_t;

  state_t                             state;
  step_t                              step;
  logic [$clog2(BOOT_POLL_MAX)-1:0]   poll_cnt; // lock reads issued

  assign req = (state == ST_REQ);

  always_comb begin
    cmd.we    = 1'b1;
    cmd.addr  = CFG1_ADDR;
    cmd.wdata = BOOT_CFG1; // enable, mul, bypass off
    case (step)
      STEP_CFG0: begin
        cmd.addr  = CFG0_ADDR;
        cmd.wdata = BOOT_CFG0; // release reset
      end
      STEP_POLL: begin
        cmd.we    = 1'b0;
        cmd.addr  = CFG2_ADDR; // lock in bit 31
        cmd.wdata = '0;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      state     <= ST_START;
      step      <= STEP_CFG1;
      poll_cnt  <= '0;
      boot_done <= 1'b0;
      boot_fail <= 1'b0;
    end else begin
      case (state)
        ST_START: state <= ST_REQ;
        ST_REQ: if (rsp.ack) begin
          state <= ST_ACKLO;
          case (step)
            STEP_CFG1: step <= STEP_CFG0;
            STEP_CFG0: step <= STEP_POLL;
            default: begin
              if (rsp.rdata[LOCK_RD_BIT]) boot_done <= 1'b1;
              else if (poll_cnt == BOOT_POLL_MAX - 1) boot_fail <= 1'b1;
              poll_cnt <= poll_cnt + 1'b1;
            end
          endcase
        end
        // wait ack low before next req
        ST_ACKLO: if (!rsp.ack) state <= (boot_done | boot_fail) ? ST_HALT : ST_REQ;
        default: ; // idle until reset
      endcase
    end
  end

endmodule

//--- hdl/clk_ctrl_top.sv
// clock control subsystem top
module clk_ctrl_top import clk_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        RSTB,
  input  logic        refclk,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        pll_clk,
  output logic        lock,
  output logic        boot_done,
  output logic        boot_fail
);

  logic      br_req;   // bridge side
  cfg_req_t  br_cmd;
  cfg_rsp_t  br_rsp;
  logic      bt_req;   // boot side
  cfg_req_t  bt_cmd;
  cfg_rsp_t  bt_rsp;
  logic      cfg_req;  // granted bus
  cfg_req_t  cfg_cmd;
  cfg_rsp_t  cfg_rsp;
  pll_ctrl_t ctrl;

  apb_cfg_bridge u_bridge (
    .clk(clk), .RSTB(RSTB), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .rsp(br_rsp), .prdata(prdata),
    .pready(pready), .pslverr(pslverr), .req(br_req), .cmd(br_cmd)
  );

  pll_boot_seq u_boot (
    .clk(clk), .RSTB(RSTB), .rsp(bt_rsp), .req(bt_req), .cmd(bt_cmd),
    .boot_done(boot_done), .boot_fail(boot_fail)
  );

  cfg_arbiter u_arb (
    .clk(clk), .RSTB(RSTB), .req_a(br_req), .req_b(bt_req),
    .cmd_a(br_cmd), .cmd_b(bt_cmd), .rsp(cfg_rsp), .rsp_a(br_rsp),
    .rsp_b(bt_rsp), .req(cfg_req), .cmd(cfg_cmd)
  );

  pll_cfg_regs u_regs (
    .clk(clk), .RSTB(RSTB), .req(cfg_req), .cmd(cfg_cmd), .lock(lock),
    .rsp(cfg_rsp), .ctrl(ctrl)
  );

  pll_model u_pll (
    .clk(clk), .RSTB(RSTB), .refclk(refclk), .ctrl(ctrl), .lock(lock),
    .pll_clk(pll_clk)
  );

endmodule

//--- test/clk_ctrl_props.sv
// clock control assertions
module clk_ctrl_props import clk_ctrl_pkg::*; (
  input logic       clk,
  input logic       RSTB,
  input logic       psel,
  input logic       penable,
  input logic       pready,
  input logic       br_req,     // bridge request
  input logic       br_ack,
  input logic       bt_req,     // boot request
  input logic       bt_ack,
  input logic       lock,
  input logic       bypass,
  input logic [7:0] ps0_l2,
  input logic       pll_clk,
  input logic       boot_fail
);

  int         fail_cnt = 0;  // read by the testbench
  logic       pll_last;
  logic [9:0] stall_cnt;     // cycles since last pll_clk edge

  always_ff @(posedge clk or negedge RSTB) begin
    if (!RSTB) begin
      pll_last  <= 1'b0;
      stall_cnt <= '0;
    end else begin
      pll_last <= pll_clk;
      if (!lock || bypass || pll_clk != pll_last) stall_cnt <= '0;
      else stall_cnt <= stall_cnt + 1'b1;
    end
  end

  a_pready_pulse: assert property (@(posedge clk) disable iff (!RSTB) pready |=> !pready)
    else begin fail_cnt++; $error("pready held longer than one cycle"); end

  a_pready_access: assert property (@(posedge clk) disable iff (!RSTB)
    pready |-> psel && penable)
    else begin fail_cnt++; $error("pready outside apb access phase"); end

  // ack reaches a requester only while it asks
  a_br_ack_on_req: assert property (@(posedge clk) disable iff (!RSTB)
    $rose(br_ack) |-> br_req)
    else begin fail_cnt++; $error("bridge got ack without a request"); end

  a_bt_ack_on_req: assert property (@(posedge clk) disable iff (!RSTB)
    $rose(bt_ack) |-> bt_req)
    else begin fail_cnt++; $error("boot sequencer got ack without a request"); end

  // first edge comes ps0_l2+1 cycles after lock
  a_pll_toggles: assert property (@(posedge clk) disable iff (!RSTB)
    lock && !bypass |-> stall_cnt <= {2'b00, ps0_l2} + 10'd2)
    else begin fail_cnt++; $error("pll_clk not toggling while locked"); end

  a_no_boot_fail: assert property (@(posedge clk) disable iff (!RSTB) !boot_fail)
    else begin fail_cnt++; $error("boot sequencer gave up on lock"); end

endmodule

bind clk_ctrl_top clk_ctrl_props u_props (
  .clk(clk), .RSTB(RSTB), .psel(psel), .penable(penable), .pready(pready),
  .br_req(br_req), .br_ack(br_rsp.ack), .bt_req(bt_req), .bt_ack(bt_rsp.ack),
  .lock(lock), .bypass(ctrl.bypass), .ps0_l2(ctrl.ps0_l2), .pll_clk(pll_clk),
  .boot_fail(boot_fail)
);

//--- test/clk_ctrl_tb.sv
// clock control testbench
module clk_ctrl_tb import clk_ctrl_pkg::*; ();

  localparam int APB_TIMEOUT  = 200;   // cycles per access
  localparam int BOOT_TIMEOUT = 2000;
  localparam int LOCK_TIMEOUT = 200;

  logic        clk;
  logic        RSTB;
  logic        refclk;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        pll_clk;
  logic        lock;
  logic        boot_done;
  logic        boot_fail;

  int          errors;
  integer      seed;
  int          cnt;
  logic [31:0] rd;
  logic [31:0] wd;
  logic [31:0] cfg2_model;  // last word written to cfg2
  logic [2:0]  lf_model;    // expected lf_hi

  clk_ctrl_top u_clk_ctrl_top (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;      // period 4
  initial refclk = 1'b0;
  always #5 refclk = ~refclk; // period 10, unrelated to clk

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // one apb transfer, setup then access until pready
  task automatic apb_access(input logic write, input logic [1:0] idx,
                            input logic [31:0] data, output logic [31:0] rdata);
    int waited;
    waited = 0;
    rdata  = 'x;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= {idx, 2'b00};  // word address
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready && waited < APB_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (pready) begin
      rdata = prdata;  // valid with pready
      check_value("pslverr", {31'd0, pslverr}, 32'd0);
    end else begin
      errors++;
      $display("APB access to cfg%0d got no pready within %0d cycles", idx, APB_TIMEOUT);
    end
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [1:0] idx, input logic [31:0] data);
    logic [31:0] unused;
    apb_access(1'b1, idx, data, unused);
  endtask

  task automatic apb_read(input logic [1:0] idx, output logic [31:0] data);
    apb_access(1'b0, idx, 32'd0, data);
  endtask

  // cfg2 readback while the pll stays locked
  function automatic logic [31:0] cfg2_expect();
    return {1'b1, lf_model[0], cfg2_model[29:0]};
  endfunction

  task automatic wait_lock(input logic level, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (lock !== level && cycles < LOCK_TIMEOUT);
    if (lock !== level) begin
      errors++;
      $display("lock did not go to %0b within %0d cycles", level, LOCK_TIMEOUT);
    end
  endtask

  // clk cycles between two pll_clk edges
  task automatic measure_half_period(output int half);
    int   waited;
    logic last;
    waited = 0;
    half   = 0;
    @(negedge clk);
    last = pll_clk;
    while (pll_clk === last && waited < 64) begin
      @(negedge clk);
      waited++;
    end
    last = pll_clk;
    @(negedge clk);
    half = 1;
    while (pll_clk === last && half < 64) begin
      @(negedge clk);
      half++;
    end
    if (pll_clk === last) begin
      errors++;
      $display("pll_clk stopped toggling while locked");
    end
  endtask

  initial begin
    errors     = 0;
    seed       = 32'h43161374;
    RSTB       = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    cfg2_model = CFG2_RST;
    lf_model   = '0;
    repeat (8) @(posedge clk);
    RSTB <= 1'b1;

    // reset values, boot may already own cfg0 and cfg1
    apb_read(CFG3_ADDR, rd);
    check_value("cfg3", rd, CFG3_RST);
    apb_read(CFG1_ADDR, rd);
    if (rd !== CFG1_RST && rd !== BOOT_CFG1) begin
      errors++;
      $display("Fail at %0t: cfg1 = %h, expected %h or %h", $time, rd, CFG1_RST, BOOT_CFG1);
    end
    apb_read(CFG0_ADDR, rd);
    if (rd !== CFG0_RST && rd !== BOOT_CFG0) begin
      errors++;
      $display("Fail at %0t: cfg0 = %h, expected %h or %h", $time, rd, CFG0_RST, BOOT_CFG0);
    end

    // boot completes with lock
    cnt = 0;
    @(negedge clk);
    while (!boot_done && cnt < BOOT_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!boot_done) begin
      errors++;
      $display("boot_done did not rise within %0d cycles", BOOT_TIMEOUT);
    end
    check_value("lock", {31'd0, lock}, 32'd1);
    apb_read(CFG1_ADDR, rd);
    check_value("cfg1", rd, BOOT_CFG1);
    measure_half_period(cnt);
    check_value("pll_clk half period", cnt, BOOT_CFG0[L2_MSB:L2_LSB] + 32'd1);

    // random round trips, cfg3 write latches old cfg2 top bits
    for (int i = 0; i < 4; i++) begin
      wd = $random(seed);
      apb_write(CFG3_ADDR, wd);
      lf_model = cfg2_model[LF_SRC_MSB:LF_SRC_LSB];
      apb_read(CFG3_ADDR, rd);
      check_value("cfg3", rd, wd);
      wd = $random(seed);
      apb_write(CFG2_ADDR, wd);
      cfg2_model = wd;
      apb_read(CFG2_ADDR, rd);
      check_value("cfg2", rd, cfg2_expect());
    end

    // lf_hi copy
    wd = $random(seed);
    wd[LF_SRC_LSB] = 1'b1;
    apb_write(CFG2_ADDR, wd);
    cfg2_model = wd;
    apb_write(CFG3_ADDR, CFG3_RST);
    lf_model = cfg2_model[LF_SRC_MSB:LF_SRC_LSB];
    apb_read(CFG2_ADDR, rd);
    check_value("cfg2", rd, cfg2_expect());
    check_value("cfg2 lf_hi bit", {31'd0, rd[LFHI_RD_BIT]}, 32'd1);

    // drop pll reset, then relock
    apb_write(CFG0_ADDR, BOOT_CFG0 & ~(32'd1 << CFG0_RSTN_BIT));
    wait_lock(1'b0, cnt);
    apb_write(CFG0_ADDR, BOOT_CFG0);
    wait_lock(1'b1, cnt);
    check_value("lock delay", cnt, LOCK_CYCLES);  // counted from access cycle
    apb_read(CFG2_ADDR, rd);
    check_value("cfg2 lock bit", {31'd0, rd[LOCK_RD_BIT]}, 32'd1);

    // bypass passes refclk
    apb_write(CFG1_ADDR, BOOT_CFG1 | (32'd1 << BYPASS_BIT));
    for (int i = 0; i < 16; i++) begin
      @(refclk);
      #1;  // settle after refclk edge
      check_value("pll_clk", {31'd0, pll_clk}, {31'd0, refclk});
    end

    repeat (4) @(posedge clk);
    $display("errors: %0d testbench, %0d assertion", errors, u_clk_ctrl_top.u_props.fail_cnt);
    if (errors == 0 && u_clk_ctrl_top.u_props.fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- all.f
hdl/clk_ctrl_pkg.sv
hdl/pll_cfg_regs.sv
hdl/pll_model.sv
hdl/cfg_arbiter.sv
hdl/apb_cfg_bridge.sv
hdl/pll_boot_seq.sv
hdl/clk_ctrl_top.sv
test/clk_ctrl_props.sv
test/clk_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# build and run the clock control simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f all.f --top-module clk_ctrl_tb -o clk_ctrl_sim

out=$(./obj_dir/clk_ctrl_sim +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -qF 'All tests passed!'; then
  exit 0
fi
exit 1
